// File: sources.f
logic/regfile_pkg.sv
logic/regfile_dpram.sv
logic/regfile_write_port.sv
logic/regfile_read_collect.sv
logic/regfile_top.sv
bench/regfile_tb.sv

// File: bench/regfile_tb.sv
`timescale 1ns/100ps
`default_nettype none

// Self-checking testbench for the register file
// Drives seeded random traffic and checks every operand against a register model
module regfile_tb
   import regfile_pkg::*;
();

   // ********************
   // Run lengths
   // ********************
   localparam int CLK_PERIOD    = 100;  // ns
   localparam int DRIVE_DELAY   = 10;   // Inputs change this long after the rising edge
   localparam int RESET_CYCLES  = 5;
   localparam int DRAIN_CYCLES  = 4;    // Lets in-flight reads land before a test closes
   localparam int WR_RD_ROUNDS  = 20;   // Up to 4 cycles each
   localparam int R0_ROUNDS     = 10;   // 2 cycles each
   localparam int BYPASS_ROUNDS = 20;   // 2 cycles each
   localparam int HOLD_CYCLES   = 300;
   localparam int MIX_CYCLES    = 2000;
   localparam int TEST_CYCLES   = RESET_CYCLES + REG_COUNT + WR_RD_ROUNDS * 4 +
                                  R0_ROUNDS * 2 + BYPASS_ROUNDS * 2 + HOLD_CYCLES +
                                  MIX_CYCLES + 6 * DRAIN_CYCLES;

   // Expected operand of one read and the edge after which it shows up
   typedef struct packed {
      int        due;
      int        port;
      reg_data_t data;
   } pend_t;

   // ********************
   // DUT signals
   // ********************
   logic                      clk_i = 1'b0;
   logic                      rst_n_i;
   wb_req_t                   wb;
   rd_req_t                   rd_req        [NUM_READ_PORTS];
   reg_data_t                 operand       [NUM_READ_PORTS];
   logic [NUM_READ_PORTS-1:0] operand_valid;

   // Model and scoreboard
   reg_data_t model   [REG_COUNT];       // Architectural register state
   reg_data_t last_op [NUM_READ_PORTS];  // Last delivered operand per port
   pend_t     pend_q  [$];               // Reads in flight, ordered by due edge
   int        edge_cnt = 0;              // Rising edges since reset release
   int        pass_cnt = 0;
   int        err_cnt  = 0;
   int        err_mark = 0;              // err_cnt at the start of the current test
   int        seed     = 32'h2b236d33;

   regfile_top i_dut (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .wb            (wb),
      .rd_req        (rd_req),
      .operand       (operand),
      .operand_valid (operand_valid)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // ********************
   // Compare tasks
   // ********************
   task automatic check_operand(input int port, input reg_data_t exp, input reg_data_t act);
      if (act !== exp) begin
         err_cnt++;
         $display("mismatch at %0t ns: port %0d operand expected %h, got %h",
                  $time, port, exp, act);
      end else begin
         pass_cnt++;
      end
   endtask

   task automatic check_valid(input int port, input logic exp, input logic act);
      if (act !== exp) begin
         err_cnt++;
         $display("mismatch at %0t ns: port %0d operand_valid expected %b, got %b",
                  $time, port, exp, act);
      end else begin
         pass_cnt++;
      end
   endtask

   // Ports with a read due after this edge must pulse and the others must hold
   task automatic check_outputs();
      logic [NUM_READ_PORTS-1:0] exp_v;
      reg_data_t                 exp_d [NUM_READ_PORTS];
      pend_t                     p;
      exp_v = '0;
      for (int k = 0; k < NUM_READ_PORTS; k++) begin
         exp_d[k] = last_op[k];  // Hold value by default
      end
      while (pend_q.size() > 0 && pend_q[0].due <= edge_cnt) begin
         p = pend_q.pop_front();
         if (p.due < edge_cnt) begin
            err_cnt++;
            $display("Error at %0t ns: port %0d operand due after edge %0d was never checked",
                     $time, p.port, p.due);
         end else begin
            exp_v[p.port] = 1'b1;
            exp_d[p.port] = p.data;
         end
      end
      for (int k = 0; k < NUM_READ_PORTS; k++) begin
         check_valid(k, exp_v[k], operand_valid[k]);
         check_operand(k, exp_d[k], operand[k]);
         last_op[k] = exp_d[k];
      end
   endtask

   // ********************
   // Stimulus helpers
   // ********************
   function automatic wb_req_t wb_op(input logic we, input reg_addr_t addr, input reg_data_t data);
      return '{we: we, addr: addr, data: data};
   endfunction

   function automatic rd_req_t rd_op(input logic re, input reg_addr_t addr);
      return '{re: re, addr: addr};
   endfunction

   function automatic reg_data_t rand_word();
      return reg_data_t'($random(seed));
   endfunction

   // Coin flip for strobes
   function automatic logic rand_bit();
      return ($random(seed) & 1) != 0;
   endfunction

   // Any register except r0
   function automatic reg_addr_t rand_reg();
      return reg_addr_t'(1 + $unsigned($random(seed)) % (REG_COUNT - 1));
   endfunction

   // Checks what the last edge produced and drives the next request
   task automatic issue_cycle(input wb_req_t w, input rd_req_t [NUM_READ_PORTS-1:0] r);
      pend_t p;
      @(posedge clk_i);
      edge_cnt++;
      #(DRIVE_DELAY);
      check_outputs();
      wb = w;
      for (int k = 0; k < NUM_READ_PORTS; k++) begin
         rd_req[k] = r[k];
         if (r[k].re) begin
            p.due  = edge_cnt + 2;  // Sampled at the next edge and delivered after the one after
            p.port = k;
            p.data = model[r[k].addr];  // Read taken before this cycle's write
            pend_q.push_back(p);
         end
      end
      if (w.we && w.addr != reg_addr_t'(0)) begin
         model[w.addr] = w.data;  // Visible to reads driven from the next cycle on
      end
   endtask

   task automatic idle(input int n);
      repeat (n) issue_cycle(wb_op(1'b0, '0, '0), '0);
   endtask

   // Drains the pipe and prints one line for the test
   task automatic finish_test(input string name);
      idle(DRAIN_CYCLES);
      if (pend_q.size() != 0) begin
         err_cnt++;
         $display("Error: %0d reads of test %s never delivered an operand", pend_q.size(), name);
         pend_q.delete();
      end
      $display("%s: %0d errors", name, err_cnt - err_mark);
      err_mark = err_cnt;
   endtask

   // ********************
   // Watchdog
   // ********************
   initial begin
      #((TEST_CYCLES + 100) * CLK_PERIOD);
      $display("Error: timeout, the tests did not finish within %0d cycles", TEST_CYCLES + 100);
      $display("Test failed");
      $finish;
   end

   // ********************
   // Test sequence
   // ********************
   initial begin
      rd_req_t [NUM_READ_PORTS-1:0] rd_all;
      reg_addr_t                    a;
      rst_n_i = 1'b0;
      wb      = '0;
      for (int k = 0; k < NUM_READ_PORTS; k++) begin
         rd_req[k]  = '0;
         last_op[k] = '0;
      end
      for (int i = 0; i < REG_COUNT; i++) begin
         model[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk_i);
      #(DRIVE_DELAY);
      rst_n_i = 1'b1;

      // Reset state and then every register read as zero on every port
      check_outputs();  // No valid, all operands zero
      for (int i = 0; i < REG_COUNT; i++) begin
         for (int k = 0; k < NUM_READ_PORTS; k++) begin
            rd_all[k] = rd_op(1'b1, reg_addr_t'((i + k) % REG_COUNT));
         end
         issue_cycle(wb_op(1'b0, '0, '0), rd_all);
      end
      finish_test("reset_state");

      // Write and a short gap before a read on both ports
      repeat (WR_RD_ROUNDS) begin
         a = rand_reg();
         issue_cycle(wb_op(1'b1, a, rand_word()), '0);
         idle($unsigned($random(seed)) % 3);  // Gap 0 lands on the bypass path
         for (int k = 0; k < NUM_READ_PORTS; k++) begin
            rd_all[k] = rd_op(1'b1, a);
         end
         issue_cycle(wb_op(1'b0, '0, '0), rd_all);
      end
      finish_test("write_then_read");

      // r0 writes must vanish for reads on the same edge and the next edge
      for (int k = 0; k < NUM_READ_PORTS; k++) begin
         rd_all[k] = rd_op(1'b1, '0);
      end
      repeat (R0_ROUNDS) begin
         issue_cycle(wb_op(1'b1, '0, rand_word()), rd_all);
         issue_cycle(wb_op(1'b0, '0, '0), rd_all);
      end
      finish_test("r0_hardwired");

      // Read at the write edge sees old data and the next read sees new data
      repeat (BYPASS_ROUNDS) begin
         a = rand_reg();
         for (int k = 0; k < NUM_READ_PORTS; k++) begin
            rd_all[k] = rd_op(1'b1, a);
         end
         issue_cycle(wb_op(1'b1, a, rand_word()), rd_all);
         issue_cycle(wb_op(1'b0, '0, '0), rd_all);
      end
      finish_test("bypass_ordering");

      // Dense reads with random gaps per port and sparse writes
      repeat (HOLD_CYCLES) begin
         for (int k = 0; k < NUM_READ_PORTS; k++) begin
            rd_all[k] = rd_op(rand_bit(), reg_addr_t'($random(seed)));
         end
         issue_cycle(wb_op(($random(seed) & 3) == 0, rand_reg(), rand_word()), rd_all);
      end
      finish_test("operand_hold");

      // Free mix including r0 writes
      repeat (MIX_CYCLES) begin
         for (int k = 0; k < NUM_READ_PORTS; k++) begin
            rd_all[k] = rd_op(rand_bit(), reg_addr_t'($random(seed)));
         end
         issue_cycle(wb_op(rand_bit(), reg_addr_t'($random(seed)), rand_word()), rd_all);
      end
      finish_test("random_mix");

      $display("checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/regfile_top.sv
`timescale 1ns/100ps
`default_nettype none

// Integer register file, one writeback port and NUM_READ_PORTS read ports
// Read latency is two cycles from the sampled strobe to the operand
module regfile_top
   import regfile_pkg::*;
(
   input  logic                      clk_i,                          // Core clock
   input  logic                      rst_n_i,                        // Async reset
   input  wb_req_t                   wb,                             // Writeback request
   input  rd_req_t                   rd_req        [NUM_READ_PORTS], // Read requests
   output reg_data_t                 operand       [NUM_READ_PORTS], // Operands to issue
   output logic [NUM_READ_PORTS-1:0] operand_valid                   // Operand strobes
);

   // ********************
   // Internal nets
   // ********************
   bank_wr_t bank_wr;                 // Shared write broadcast
   rd_resp_t resp [NUM_READ_PORTS];   // One response per copy

   // Writeback stage, filters r0
   regfile_write_port i_write_port (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wb      (wb),
      .bank_wr (bank_wr)
   );

   // ********************
   // Bank copies
   // ********************

   // One RAM copy per read port, all fed the same writes
   generate
      for (genvar k = 0; k < NUM_READ_PORTS; k++) begin : gen_bank
         regfile_dpram i_dpram (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .bank_wr (bank_wr),
            .rd_req  (rd_req[k]),
            .resp    (resp[k])
         );
      end
   endgenerate

   // Holds operands between reads
   regfile_read_collect i_read_collect (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .resp          (resp),
      .operand       (operand),
      .operand_valid (operand_valid)
   );

endmodule

`default_nettype wire

// File: logic/regfile_read_collect.sv
`timescale 1ns/100ps
`default_nettype none

// Read collector
// Turns the gated RAM responses into operands that an issue stage can hold
module regfile_read_collect
   import regfile_pkg::*;
(
   input  logic                      clk_i,                          // Core clock
   input  logic                      rst_n_i,                        // Async reset
   input  rd_resp_t                  resp          [NUM_READ_PORTS], // Per-copy responses
   output reg_data_t                 operand       [NUM_READ_PORTS], // Held operands
   output logic [NUM_READ_PORTS-1:0] operand_valid                   // One pulse per read
);

   // ********************
   // Response unpacking
   // ********************
   logic [NUM_READ_PORTS-1:0] resp_valid;  // Valid bits of all copies
   reg_data_t                 resp_data [NUM_READ_PORTS];

   // Pull the struct fields apart once, per port
   always_comb begin
      for (int k = 0; k < NUM_READ_PORTS; k++) begin
         resp_valid[k] = resp[k].valid;
         resp_data[k]  = resp[k].data;
      end
   end

   // ********************
   // Per-port registers
   // ********************
   generate
      for (genvar k = 0; k < NUM_READ_PORTS; k++) begin : gen_port

         // Operand hold
         // Loads only on a valid response, so RAM idle zeros never reach it
         always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               operand[k] <= '0;
            end else if (resp_valid[k]) begin
               operand[k] <= resp_data[k];
            end
         end

         // Operand valid
         // Mirrors the response strobe one cycle later
         always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               operand_valid[k] <= 1'b0;
            end else begin
               operand_valid[k] <= resp_valid[k];  // Back-to-back reads give back-to-back pulses
            end
         end

      end
   endgenerate

endmodule

`default_nettype wire

// File: logic/regfile_write_port.sv
`timescale 1ns/100ps
`default_nettype none

// Writeback register stage
// Samples the core request, drops r0 writes and feeds all RAM copies
module regfile_write_port
   import regfile_pkg::*;
(
   input  logic     clk_i,    // Core clock
   input  logic     rst_n_i,  // Async reset, active low
   input  wb_req_t  wb,       // Writeback request from the core
   output bank_wr_t bank_wr   // Broadcast to every RAM copy
);

   // ********************
   // Qualification
   // ********************
   logic wb_to_r0;   // Request targets the hard-wired zero register
   logic wb_accept;  // Request really updates the bank

   assign wb_to_r0  = (wb.addr == reg_addr_t'(0));
   assign wb_accept = wb.we & ~wb_to_r0;  // r0 writes vanish here

   // ********************
   // Stage registers
   // ********************
   logic      we_r;    // Write strobe toward the copies
   reg_addr_t addr_r;  // Destination index
   reg_data_t data_r;  // Result word

   // Strobe is control state
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         we_r <= 1'b0;
      end else begin
         we_r <= wb_accept;  // One-cycle pulse per accepted request
      end
   end

   // Payload loads only on accepted requests
   always_ff @(posedge clk_i) begin
      if (wb_accept) begin
         addr_r <= wb.addr;
         data_r <= wb.data;
      end
   end

   // Same word goes to every copy, keeping them identical
   assign bank_wr = '{we: we_r, addr: addr_r, data: data_r};

   // ********************
   // Checks
   // ********************

   // A write to r0 would break the zero register in every copy at once
   a_no_r0_write : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      bank_wr.we |-> (bank_wr.addr != reg_addr_t'(0)))
      else $error("bank write aimed at r0");

   // Unknown index would scatter X over the bank copies
   a_wr_addr_known : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      bank_wr.we |-> !$isunknown(bank_wr.addr))
      else $error("bank write with unknown register index");

endmodule

`default_nettype wire

// File: logic/regfile_dpram.sv
`timescale 1ns/100ps
`default_nettype none

// One copy of the register bank
// Write side shared by all copies, read side owned by a single read port
module regfile_dpram
   import regfile_pkg::*;
(
   input  logic     clk_i,    // Core clock
   input  logic     rst_n_i,  // Async reset, active low
   input  bank_wr_t bank_wr,  // Broadcast write from the write port
   input  rd_req_t  rd_req,   // Read request of this port
   output rd_resp_t resp      // Read response, one cycle after the strobe
);

   // ********************
   // Storage
   // ********************
   reg_data_t mem [REG_COUNT];  // Register words, r0 is never written

   reg_data_t dout_r;  // Word read from the array
   logic      re_r;    // Delayed read strobe, becomes resp.valid

   // Bypass path
   reg_data_t din_r;      // Write data captured alongside a read
   logic      bypass;     // Read hit the address written on the same edge
   logic      rw_hit;     // Same-edge read/write collision on a live register
   reg_data_t dout_w;     // Array word or bypassed word

   // Contents start at zero, no reset on the array
   initial begin
      for (int i = 0; i < REG_COUNT; i++) begin
         mem[i] = '0;
      end
   end

   // ********************
   // Write and read
   // ********************

   // Array write and synchronous read, read returns the old word on a collision
   always_ff @(posedge clk_i) begin
      if (bank_wr.we) begin
         mem[bank_wr.addr] <= bank_wr.data;
      end
      if (rd_req.re) begin
         dout_r <= mem[rd_req.addr];
      end
   end

   // Read strobe delay, forms the response valid
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         re_r <= 1'b0;
      end else begin
         re_r <= rd_req.re;
      end
   end

   // ********************
   // Write-to-read bypass
   // ********************

   // r0 excluded, it must keep reading as zero
   assign rw_hit = rd_req.re & bank_wr.we &
                   (rd_req.addr == bank_wr.addr) &
                   (|rd_req.addr);

   // Data side only matters when bypass is set
   always_ff @(posedge clk_i) begin
      if (rd_req.re) begin
         din_r <= bank_wr.data;  // Newest word for this read
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bypass <= 1'b0;
      end else begin
         bypass <= rw_hit;  // Cleared by the next edge without a hit
      end
   end

   assign dout_w = bypass ? din_r : dout_r;

   // ********************
   // Response
   // ********************

   // Gated so idle cycles read as zero
   assign resp.valid = re_r;
   assign resp.data  = re_r ? dout_w : '0;

   // A strobed read with an unknown index would poison the operand later
   a_rd_addr_known : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      rd_req.re |-> !$isunknown(rd_req.addr))
      else $error("read strobe with unknown register index");

endmodule

`default_nettype wire

// File: logic/regfile_pkg.sv
`default_nettype none

// Shared types and sizes for the integer register file
package regfile_pkg;

   // ********************
   // Sizes
   // ********************
   localparam int REG_ADDR_WIDTH = 5;                    // 32 architectural registers
   localparam int REG_DATA_WIDTH = 32;                   // One register word
   localparam int NUM_READ_PORTS = 2;                    // Read ports, one RAM copy each
   localparam int REG_COUNT      = 1 << REG_ADDR_WIDTH;  // Depth of every RAM copy

   // ********************
   // Scalar types
   // ********************
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;  // Register index
   typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;  // Register word

   // ********************
   // Bundles
   // ********************

   // Writeback request, straight from the core
   typedef struct packed {
      logic      we;    // Single-cycle write strobe
      reg_addr_t addr;  // Destination register
      reg_data_t data;  // Result word
   } wb_req_t;

   // Write broadcast to every RAM copy, never targets r0
   typedef struct packed {
      logic      we;
      reg_addr_t addr;
      reg_data_t data;
   } bank_wr_t;

   // One read port request
   typedef struct packed {
      logic      re;    // Single-cycle read strobe
      reg_addr_t addr;  // Source register
   } rd_req_t;

   // Response of one RAM copy, data is zero while valid is low
   typedef struct packed {
      logic      valid;
      reg_data_t data;
   } rd_resp_t;

endpackage

`default_nettype wire
